/* bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    // word-wide address and instruction
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // 2-bit saturating direction counter
    typedef logic [1:0] ctr_t;
    localparam ctr_t CTR_RESET = 2'd1; // weakly not taken

    // btb geometry, indexed by pc[9:2]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [31-BTB_IDX_W-2:0] btb_tag_t; // pc[31:10]

    // major opcodes
    typedef logic [6:0] opcode_t;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        TR_IDLE,  // waiting for a queued update
        TR_READ,  // waiting for the read port
        TR_WRITE  // counter and btb write
    } trainer_state_t;

endpackage

`default_nettype wire

/* bpu_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_lookup (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 lookup_valid_i,
    input  wire bpu_pkg::addr_t lookup_pc_i,
    input  wire bpu_pkg::inst_t lookup_inst_i,
    input  wire bpu_pkg::ctr_t  rd_ctr_i,
    input  wire                 rd_btb_hit_i,
    input  wire bpu_pkg::addr_t rd_btb_target_i,
    output logic                rd_req_o,
    output bpu_pkg::addr_t      rd_pc_o,
    output logic                pred_valid_o,
    output logic                pred_is_cti_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_target_o
);

    bpu_pkg::opcode_t opcode;
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    bpu_pkg::addr_t   b_imm;
    bpu_pkg::addr_t   j_imm;
    bpu_pkg::addr_t   pc_plus4;
    logic             is_cti_d;
    logic             taken_d;
    bpu_pkg::addr_t   target_d;

    // lookup always wins the read port
    assign rd_req_o = lookup_valid_i;
    assign rd_pc_o  = lookup_pc_i;

    assign opcode    = lookup_inst_i[6:0];
    assign is_branch = (opcode == bpu_pkg::OPC_BRANCH);
    assign is_jal    = (opcode == bpu_pkg::OPC_JAL);
    assign is_jalr   = (opcode == bpu_pkg::OPC_JALR);

    // B-type offset
    assign b_imm = {{20{lookup_inst_i[31]}}, lookup_inst_i[7], lookup_inst_i[30:25],
                    lookup_inst_i[11:8], 1'b0};
    // J-type offset
    assign j_imm = {{12{lookup_inst_i[31]}}, lookup_inst_i[19:12], lookup_inst_i[20],
                    lookup_inst_i[30:21], 1'b0};

    assign pc_plus4 = lookup_pc_i + 32'd4;

    always_comb begin
        is_cti_d = 1'b0;
        taken_d  = 1'b0;
        target_d = pc_plus4; // fall through
        if (is_branch) begin
            is_cti_d = 1'b1;
            taken_d  = rd_ctr_i[1]; // counter msb is the direction
            if (rd_ctr_i[1]) begin
                target_d = rd_btb_hit_i ? rd_btb_target_i : lookup_pc_i + b_imm;
            end
        end else if (is_jal) begin
            is_cti_d = 1'b1;
            taken_d  = 1'b1;
            target_d = rd_btb_hit_i ? rd_btb_target_i : lookup_pc_i + j_imm;
        end else if (is_jalr) begin
            // register target unknown at fetch, only the btb can help
            is_cti_d = 1'b1;
            taken_d  = rd_btb_hit_i;
            if (rd_btb_hit_i) begin
                target_d = rd_btb_target_i;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= lookup_valid_i;
        end
    end

    // prediction fields only load with a lookup
    always_ff @(posedge clk) begin
        if (lookup_valid_i) begin
            pred_is_cti_o <= is_cti_d;
            pred_taken_o  <= taken_d;
            pred_target_o <= target_d;
        end
    end

endmodule

`default_nettype wire

/* bpu_tables.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_tables #(
    parameter int BHT_ENTRIES = 512
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rd_req_i,
    input  wire bpu_pkg::addr_t rd_lookup_pc_i,
    input  wire bpu_pkg::addr_t rd_train_pc_i,
    input  wire                 ctr_we_i,
    input  wire bpu_pkg::ctr_t  ctr_wdata_i,
    input  wire                 btb_we_i,
    input  wire bpu_pkg::addr_t wr_pc_i,
    input  wire bpu_pkg::addr_t wr_target_i,
    output bpu_pkg::ctr_t       rd_ctr_o,
    output logic                rd_btb_hit_o,
    output bpu_pkg::addr_t      rd_btb_target_o,
    output logic                train_grant_o
);

    localparam int BHT_IDX_W = $clog2(BHT_ENTRIES);
    localparam int BTB_LSB   = 2;
    localparam int TAG_LSB   = bpu_pkg::BTB_IDX_W + BTB_LSB;

    typedef logic [BHT_IDX_W-1:0] bht_idx_t;

    bpu_pkg::ctr_t     ctr_q        [BHT_ENTRIES];
    bpu_pkg::btb_tag_t btb_tag_q    [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t    btb_target_q [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::BTB_ENTRIES-1:0] btb_valid_q;

    bpu_pkg::addr_t    rd_pc;
    bht_idx_t          rd_bht_idx;
    bpu_pkg::btb_idx_t rd_btb_idx;
    bpu_pkg::btb_tag_t rd_tag;
    bht_idx_t          wr_bht_idx;
    bpu_pkg::btb_idx_t wr_btb_idx;
    bpu_pkg::btb_tag_t wr_tag;

    // single read port, lookup first
    assign train_grant_o = ~rd_req_i;
    assign rd_pc         = rd_req_i ? rd_lookup_pc_i : rd_train_pc_i;

    assign rd_bht_idx = rd_pc[BHT_IDX_W:1];
    assign rd_btb_idx = rd_pc[TAG_LSB-1:BTB_LSB];
    assign rd_tag     = rd_pc[31:TAG_LSB];
    assign wr_bht_idx = wr_pc_i[BHT_IDX_W:1];
    assign wr_btb_idx = wr_pc_i[TAG_LSB-1:BTB_LSB];
    assign wr_tag     = wr_pc_i[31:TAG_LSB];

    // reads see contents before this cycle's write
    assign rd_ctr_o        = ctr_q[rd_bht_idx];
    assign rd_btb_hit_o    = btb_valid_q[rd_btb_idx] && (btb_tag_q[rd_btb_idx] == rd_tag);
    assign rd_btb_target_o = btb_target_q[rd_btb_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_RESET;
            end
            btb_valid_q <= '0;
        end else begin
            if (ctr_we_i) begin
                ctr_q[wr_bht_idx] <= ctr_wdata_i;
            end
            if (btb_we_i) begin
                btb_valid_q[wr_btb_idx] <= 1'b1;
            end
        end
    end

    // btb payload, qualified by the valid bit
    always_ff @(posedge clk) begin
        if (btb_we_i) begin
            btb_tag_q[wr_btb_idx]    <= wr_tag;
            btb_target_q[wr_btb_idx] <= wr_target_i;
        end
    end

endmodule

`default_nettype wire

/* bpu_update_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_update_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 push_valid_i,
    input  wire bpu_pkg::addr_t push_pc_i,
    input  wire                 push_taken_i,
    input  wire bpu_pkg::addr_t push_target_i,
    input  wire                 pop_ready_i,
    output logic                push_ready_o,
    output logic                pop_valid_o,
    output bpu_pkg::addr_t      pop_pc_o,
    output logic                pop_taken_o,
    output bpu_pkg::addr_t      pop_target_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    bpu_pkg::addr_t         pc_mem     [QUEUE_DEPTH];
    bpu_pkg::addr_t         target_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] taken_mem;

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q; // one extra bit to tell full from empty
    logic             push_fire;
    logic             pop_fire;

    assign push_ready_o = (count_q != (PTR_W+1)'(QUEUE_DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign push_fire    = push_valid_i & push_ready_o;
    assign pop_fire     = pop_valid_o & pop_ready_i;

    assign pop_pc_o     = pc_mem[rd_ptr_q];
    assign pop_taken_o  = taken_mem[rd_ptr_q];
    assign pop_target_o = target_mem[rd_ptr_q];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is a power of two
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count_q <= count_q + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            pc_mem[wr_ptr_q]     <= push_pc_i;
            taken_mem[wr_ptr_q]  <= push_taken_i;
            target_mem[wr_ptr_q] <= push_target_i;
        end
    end

endmodule

`default_nettype wire

/* bpu_trainer.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_trainer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 pop_valid_i,
    input  wire bpu_pkg::addr_t pop_pc_i,
    input  wire                 pop_taken_i,
    input  wire bpu_pkg::addr_t pop_target_i,
    input  wire                 grant_i,
    input  wire bpu_pkg::ctr_t  rd_ctr_i,
    output logic                pop_ready_o,
    output bpu_pkg::addr_t      rd_pc_o,
    output logic                ctr_we_o,
    output bpu_pkg::ctr_t       ctr_wdata_o,
    output logic                btb_we_o,
    output bpu_pkg::addr_t      wr_pc_o,
    output bpu_pkg::addr_t      wr_target_o
);

    bpu_pkg::trainer_state_t state_q;
    bpu_pkg::addr_t          pc_q;     // popped item
    logic                    taken_q;
    bpu_pkg::addr_t          target_q;
    bpu_pkg::ctr_t           ctr_q;    // counter sampled in TR_READ

    assign pop_ready_o = (state_q == bpu_pkg::TR_IDLE);
    assign rd_pc_o     = pc_q;
    assign wr_pc_o     = pc_q;
    assign wr_target_o = target_q;
    assign ctr_we_o    = (state_q == bpu_pkg::TR_WRITE);
    assign btb_we_o    = (state_q == bpu_pkg::TR_WRITE) && taken_q; // taken only

    // saturating step
    always_comb begin
        if (taken_q) begin
            ctr_wdata_o = (ctr_q == 2'd3) ? ctr_q : ctr_q + 2'd1;
        end else begin
            ctr_wdata_o = (ctr_q == 2'd0) ? ctr_q : ctr_q - 2'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= bpu_pkg::TR_IDLE;
        end else begin
            case (state_q)
                bpu_pkg::TR_IDLE:  if (pop_valid_i) state_q <= bpu_pkg::TR_READ;
                bpu_pkg::TR_READ:  if (grant_i) state_q <= bpu_pkg::TR_WRITE;
                bpu_pkg::TR_WRITE: state_q <= bpu_pkg::TR_IDLE;
                default:           state_q <= bpu_pkg::TR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_ready_o && pop_valid_i) begin
            pc_q     <= pop_pc_i;
            taken_q  <= pop_taken_i;
            target_q <= pop_target_i;
        end
        if (state_q == bpu_pkg::TR_READ && grant_i) begin
            ctr_q <= rd_ctr_i;
        end
    end

endmodule

`default_nettype wire

/* bpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bpu_top #(
    parameter int BHT_ENTRIES = 512,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                 clk,
    input  wire                 rst,
    // fetch lookup
    input  wire                 lookup_valid_i,
    input  wire bpu_pkg::addr_t lookup_pc_i,
    input  wire bpu_pkg::inst_t lookup_inst_i,
    // prediction, one cycle after lookup
    output logic                pred_valid_o,
    output logic                pred_is_cti_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_target_o,
    // resolved branch updates
    input  wire                 upd_valid_i,
    output logic                upd_ready_o,
    input  wire bpu_pkg::addr_t upd_pc_i,
    input  wire                 upd_taken_i,
    input  wire bpu_pkg::addr_t upd_target_i
);

    logic           rd_req;
    bpu_pkg::addr_t rd_lookup_pc;
    bpu_pkg::addr_t rd_train_pc;
    bpu_pkg::ctr_t  rd_ctr;
    logic           rd_btb_hit;
    bpu_pkg::addr_t rd_btb_target;
    logic           train_grant;

    // queue head to trainer
    logic           q_valid;
    logic           q_ready;
    bpu_pkg::addr_t q_pc;
    logic           q_taken;
    bpu_pkg::addr_t q_target;

    // trainer write port
    logic           ctr_we;
    bpu_pkg::ctr_t  ctr_wdata;
    logic           btb_we;
    bpu_pkg::addr_t wr_pc;
    bpu_pkg::addr_t wr_target;

    bpu_lookup i_lookup (
        .clk             (clk),
        .rst             (rst),
        .lookup_valid_i  (lookup_valid_i),
        .lookup_pc_i     (lookup_pc_i),
        .lookup_inst_i   (lookup_inst_i),
        .rd_ctr_i        (rd_ctr),
        .rd_btb_hit_i    (rd_btb_hit),
        .rd_btb_target_i (rd_btb_target),
        .rd_req_o        (rd_req),
        .rd_pc_o         (rd_lookup_pc),
        .pred_valid_o    (pred_valid_o),
        .pred_is_cti_o   (pred_is_cti_o),
        .pred_taken_o    (pred_taken_o),
        .pred_target_o   (pred_target_o)
    );

    bpu_tables #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) i_tables (
        .clk             (clk),
        .rst             (rst),
        .rd_req_i        (rd_req),
        .rd_lookup_pc_i  (rd_lookup_pc),
        .rd_train_pc_i   (rd_train_pc),
        .ctr_we_i        (ctr_we),
        .ctr_wdata_i     (ctr_wdata),
        .btb_we_i        (btb_we),
        .wr_pc_i         (wr_pc),
        .wr_target_i     (wr_target),
        .rd_ctr_o        (rd_ctr),
        .rd_btb_hit_o    (rd_btb_hit),
        .rd_btb_target_o (rd_btb_target),
        .train_grant_o   (train_grant)
    );

    bpu_update_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_update_queue (
        .clk           (clk),
        .rst           (rst),
        .push_valid_i  (upd_valid_i),
        .push_pc_i     (upd_pc_i),
        .push_taken_i  (upd_taken_i),
        .push_target_i (upd_target_i),
        .pop_ready_i   (q_ready),
        .push_ready_o  (upd_ready_o),
        .pop_valid_o   (q_valid),
        .pop_pc_o      (q_pc),
        .pop_taken_o   (q_taken),
        .pop_target_o  (q_target)
    );

    bpu_trainer i_trainer (
        .clk          (clk),
        .rst          (rst),
        .pop_valid_i  (q_valid),
        .pop_pc_i     (q_pc),
        .pop_taken_i  (q_taken),
        .pop_target_i (q_target),
        .grant_i      (train_grant),
        .rd_ctr_i     (rd_ctr),
        .pop_ready_o  (q_ready),
        .rd_pc_o      (rd_train_pc),
        .ctr_we_o     (ctr_we),
        .ctr_wdata_o  (ctr_wdata),
        .btb_we_o     (btb_we),
        .wr_pc_o      (wr_pc),
        .wr_target_o  (wr_target)
    );

endmodule

`default_nettype wire

/* tb_bpu_model.svh */
`ifndef TB_BPU_MODEL_SVH
`define TB_BPU_MODEL_SVH

localparam int MDL_BHT_ENTRIES = 512;
localparam int MDL_QUEUE_DEPTH = 4;
localparam int MDL_BHT_IDX_W   = $clog2(MDL_BHT_ENTRIES);
localparam int MDL_TAG_LSB     = bpu_pkg::BTB_IDX_W + 2;

// mirror of the dut tables
bpu_pkg::ctr_t     m_ctr        [MDL_BHT_ENTRIES];
bpu_pkg::btb_tag_t m_btb_tag    [bpu_pkg::BTB_ENTRIES];
bpu_pkg::addr_t    m_btb_target [bpu_pkg::BTB_ENTRIES];
logic              m_btb_valid  [bpu_pkg::BTB_ENTRIES];

logic [31:0] lcg_state = 32'hc795_ec7f;

task automatic model_reset();
    for (int i = 0; i < MDL_BHT_ENTRIES; i++) begin
        m_ctr[i] = bpu_pkg::CTR_RESET;
    end
    for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) begin
        m_btb_valid[i] = 1'b0;
    end
endtask

function automatic void predict(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst,
                                output logic is_cti, output logic taken,
                                output bpu_pkg::addr_t target);
    bpu_pkg::btb_idx_t bi;
    logic              hit;
    bpu_pkg::addr_t    b_imm;
    bpu_pkg::addr_t    j_imm;
    bi     = pc[MDL_TAG_LSB-1:2];
    hit    = m_btb_valid[bi] && (m_btb_tag[bi] == pc[31:MDL_TAG_LSB]);
    b_imm  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    j_imm  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    is_cti = 1'b1;
    taken  = 1'b0;
    target = pc + 32'd4;
    case (inst[6:0])
        bpu_pkg::OPC_BRANCH: begin
            taken = m_ctr[pc[MDL_BHT_IDX_W:1]][1];
            if (taken) target = hit ? m_btb_target[bi] : pc + b_imm;
        end
        bpu_pkg::OPC_JAL: begin
            taken  = 1'b1;
            target = hit ? m_btb_target[bi] : pc + j_imm;
        end
        bpu_pkg::OPC_JALR: begin
            taken = hit;
            if (hit) target = m_btb_target[bi];
        end
        default: is_cti = 1'b0;
    endcase
endfunction

// same rule as the trainer
task automatic model_update(input bpu_pkg::addr_t pc, input logic taken,
                            input bpu_pkg::addr_t target);
    int unsigned       ci;
    bpu_pkg::btb_idx_t bi;
    ci = pc[MDL_BHT_IDX_W:1];
    bi = pc[MDL_TAG_LSB-1:2];
    if (taken) begin
        if (m_ctr[ci] != 2'd3) m_ctr[ci] = m_ctr[ci] + 2'd1;
        m_btb_tag[bi]    = pc[31:MDL_TAG_LSB];
        m_btb_target[bi] = target;
        m_btb_valid[bi]  = 1'b1;
    end else if (m_ctr[ci] != 2'd0) begin
        m_ctr[ci] = m_ctr[ci] - 2'd1;
    end
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`endif

/* tb_bpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bpu_top;

    `include "tb_bpu_model.svh"

    localparam int DRAIN_CYCLES = 3 * (MDL_QUEUE_DEPTH + 1);
    localparam int WAIT_LIMIT   = 200;
    localparam bpu_pkg::inst_t INST_ADDI = 32'h0000_0013; // addi x0, x0, 0
    localparam bpu_pkg::inst_t INST_JALR = {12'h010, 5'd1, 3'b000, 5'd0, bpu_pkg::OPC_JALR};

    logic           clk;
    logic           rst;
    logic           lookup_valid;
    bpu_pkg::addr_t lookup_pc;
    bpu_pkg::inst_t lookup_inst;
    logic           pred_valid;
    logic           pred_is_cti;
    logic           pred_taken;
    bpu_pkg::addr_t pred_target;
    logic           upd_valid;
    logic           upd_ready;
    bpu_pkg::addr_t upd_pc;
    logic           upd_taken;
    bpu_pkg::addr_t upd_target;

    // accepted updates not yet folded into the model
    bpu_pkg::addr_t pend_pc     [$];
    logic           pend_taken  [$];
    bpu_pkg::addr_t pend_target [$];

    logic           exp_valid;
    logic           exp_cti;
    logic           exp_taken;
    bpu_pkg::addr_t exp_target;

    bpu_top i_bpu_top (
        .clk            (clk),
        .rst            (rst),
        .lookup_valid_i (lookup_valid),
        .lookup_pc_i    (lookup_pc),
        .lookup_inst_i  (lookup_inst),
        .pred_valid_o   (pred_valid),
        .pred_is_cti_o  (pred_is_cti),
        .pred_taken_o   (pred_taken),
        .pred_target_o  (pred_target),
        .upd_valid_i    (upd_valid),
        .upd_ready_o    (upd_ready),
        .upd_pc_i       (upd_pc),
        .upd_taken_i    (upd_taken),
        .upd_target_i   (upd_target)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
            else report_fail($sformatf("FAIL %s expected %h got %h", name, exp, got));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // each lookup sampled at an edge is checked at the following falling edge
    initial begin
        forever begin
            @(posedge clk);
            exp_valid = lookup_valid && !rst;
            if (exp_valid) begin
                predict(lookup_pc, lookup_inst, exp_cti, exp_taken, exp_target);
            end
            @(negedge clk);
            check_val("pred_valid_o", 32'(exp_valid), 32'(pred_valid));
            if (exp_valid) begin
                check_val("pred_is_cti_o", 32'(exp_cti), 32'(pred_is_cti));
                check_val("pred_taken_o", 32'(exp_taken), 32'(pred_taken));
                check_val("pred_target_o", exp_target, pred_target);
            end
        end
    end

    // RISC-V encoders taking byte offsets
    function automatic bpu_pkg::inst_t enc_branch(input bpu_pkg::addr_t imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], bpu_pkg::OPC_BRANCH};
    endfunction

    function automatic bpu_pkg::inst_t enc_jal(input bpu_pkg::addr_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, bpu_pkg::OPC_JAL};
    endfunction

    function automatic bpu_pkg::addr_t rand_pc();
        logic [31:0] r;
        r = lcg_next();
        return {19'd0, r[31:21], 2'b00}; // small pool with tags aliasing on bits 12..10
    endfunction

    function automatic bpu_pkg::inst_t rand_inst();
        logic [31:0]    r;
        logic [31:0]    sel;
        bpu_pkg::inst_t inst;
        r   = lcg_next();
        sel = lcg_next();
        case (sel[31:30])
            2'd0:    inst = {r[31:7], bpu_pkg::OPC_BRANCH};
            2'd1:    inst = {r[31:7], bpu_pkg::OPC_JAL};
            2'd2:    inst = {r[31:7], bpu_pkg::OPC_JALR};
            default: inst = {r[31:7], 7'b0010011};
        endcase
        return inst;
    endfunction

    task automatic lookup(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst);
        lookup_valid = 1'b1;
        lookup_pc    = pc;
        lookup_inst  = inst;
        next_cycle();
        lookup_valid = 1'b0;
    endtask

    task automatic check_lookup(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst,
                                input logic cti, input logic taken, input bpu_pkg::addr_t target);
        lookup(pc, inst);
        check_val("pred_is_cti_o", 32'(cti), 32'(pred_is_cti));
        check_val("pred_taken_o", 32'(taken), 32'(pred_taken));
        check_val("pred_target_o", target, pred_target);
    endtask

    task automatic send_update(input bpu_pkg::addr_t pc, input logic taken,
                               input bpu_pkg::addr_t target);
        int waited;
        waited     = 0;
        upd_valid  = 1'b1;
        upd_pc     = pc;
        upd_taken  = taken;
        upd_target = target;
        while (!upd_ready) begin
            next_cycle();
            waited++;
            assert (waited <= WAIT_LIMIT)
                else report_fail("update channel never became ready");
        end
        next_cycle();
        upd_valid = 1'b0;
        pend_pc.push_back(pc);
        pend_taken.push_back(taken);
        pend_target.push_back(target);
    endtask

    // idle gap long enough for the trainer to empty the queue
    task automatic drain();
        repeat (DRAIN_CYCLES) next_cycle();
        while (pend_pc.size() > 0) begin
            model_update(pend_pc.pop_front(), pend_taken.pop_front(), pend_target.pop_front());
        end
    endtask

    task automatic check_reset_state();
        check_val("upd_ready_o", 32'd1, 32'(upd_ready));
        check_lookup(32'h0000_0100, enc_branch(32'h40), 1'b1, 1'b0, 32'h0000_0104);
        check_lookup(32'h0000_0200, enc_jal(32'hffff_ff00), 1'b1, 1'b1, 32'h0000_0100);
        check_lookup(32'h0000_0300, INST_JALR, 1'b1, 1'b0, 32'h0000_0304);
        check_lookup(32'h0000_0400, INST_ADDI, 1'b0, 1'b0, 32'h0000_0404);
    endtask

    task automatic check_counter_training();
        bpu_pkg::addr_t pc;
        bpu_pkg::addr_t target;
        pc     = 32'h0000_1040;
        target = 32'h0000_5000;
        repeat (2) send_update(pc, 1'b1, target);
        drain();
        check_lookup(pc, enc_branch(32'h80), 1'b1, 1'b1, target);
        repeat (2) send_update(pc, 1'b1, target); // counter pinned at 3
        drain();
        check_lookup(pc, enc_branch(32'h80), 1'b1, 1'b1, target);
        repeat (3) send_update(pc, 1'b0, 32'h0);
        drain();
        check_lookup(pc, enc_branch(32'h80), 1'b1, 1'b0, pc + 32'd4);
        check_lookup(pc, enc_jal(32'h20), 1'b1, 1'b1, target); // btb entry kept
    endtask

    task automatic check_btb_tags();
        bpu_pkg::addr_t pc;
        bpu_pkg::addr_t alias_pc;
        bpu_pkg::addr_t target;
        pc       = 32'h0000_2080;
        alias_pc = pc ^ 32'h0000_1000; // same set with another tag
        target   = 32'h0000_8000;
        send_update(pc, 1'b1, target);
        drain();
        check_lookup(pc, enc_jal(32'h40), 1'b1, 1'b1, target);
        check_lookup(pc, INST_JALR, 1'b1, 1'b1, target);
        check_lookup(alias_pc, enc_jal(32'h40), 1'b1, 1'b1, alias_pc + 32'h40);
        check_lookup(alias_pc, INST_JALR, 1'b1, 1'b0, alias_pc + 32'd4);
    endtask

    task automatic check_back_pressure();
        int accepted;
        int waited;
        accepted = 0;
        waited   = 0;
        // lookups every cycle keep the trainer off the read port
        for (int c = 0; c < MDL_QUEUE_DEPTH + 8; c++) begin
            lookup_valid = 1'b1;
            lookup_pc    = rand_pc();
            lookup_inst  = rand_inst();
            upd_valid    = 1'b1;
            upd_pc       = 32'h0000_6000 + 32'(accepted) * 32'd4;
            upd_taken    = 1'b1;
            upd_target   = 32'h0001_0000 + 32'(accepted) * 32'h100;
            if (upd_ready) begin
                pend_pc.push_back(upd_pc);
                pend_taken.push_back(1'b1);
                pend_target.push_back(upd_target);
                accepted++;
            end
            next_cycle();
        end
        check_val("upd_ready_o", 32'd0, 32'(upd_ready));
        check_val("accepted updates", 32'(MDL_QUEUE_DEPTH + 1), 32'(accepted));
        lookup_valid = 1'b0;
        upd_valid    = 1'b0;
        while (!upd_ready) begin
            next_cycle();
            waited++;
            assert (waited <= WAIT_LIMIT)
                else report_fail("update queue stayed full after lookups stopped");
        end
        drain();
        for (int i = 0; i < accepted; i++) begin
            check_lookup(32'h0000_6000 + 32'(i) * 32'd4, enc_jal(32'h40), 1'b1, 1'b1,
                         32'h0001_0000 + 32'(i) * 32'h100);
        end
    endtask

    task automatic run_random_mix();
        int             n;
        logic [31:0]    r;
        bpu_pkg::addr_t pc;
        bpu_pkg::addr_t target;
        bpu_pkg::inst_t inst;
        for (int b = 0; b < 12; b++) begin
            r = lcg_next();
            n = 1 + int'(r[31:29]); // may exceed the queue depth
            for (int i = 0; i < n; i++) begin
                r      = lcg_next();
                pc     = rand_pc();
                target = rand_pc();
                send_update(pc, r[31], target);
            end
            drain();
            for (int i = 0; i < 24; i++) begin
                pc   = rand_pc();
                inst = rand_inst();
                lookup(pc, inst);
            end
        end
    endtask

    initial begin
        rst          = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        lookup_inst  = '0;
        upd_valid    = 1'b0;
        upd_pc       = '0;
        upd_taken    = 1'b0;
        upd_target   = '0;
        model_reset();
        #1 rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        check_reset_state();
        check_counter_training();
        check_btb_tags();
        check_back_pressure();
        run_random_mix();
        repeat (2) next_cycle(); // last prediction still in the compare
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bpu_top.f */
+incdir+.
bpu_pkg.sv
bpu_lookup.sv
bpu_tables.sv
bpu_update_queue.sv
bpu_trainer.sv
bpu_top.sv
tb_bpu_top.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - files:
      - bpu_pkg.sv
      - bpu_lookup.sv
      - bpu_tables.sv
      - bpu_update_queue.sv
      - bpu_trainer.sv
      - bpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_bpu_top.sv
